// ==== flist.f ====
gamePkg.sv
spawnPicker.sv
playerUnit.sv
chaserUnit.sv
sweepUnit.sv
gameReferee.sv
gameTop.sv
tbClock.sv
gameTop_sva.sv
gameTop_tb.sv

// ==== Bender.yml ====
package:
  name: game_engine

sources:
  - gamePkg.sv
  - spawnPicker.sv
  - playerUnit.sv
  - chaserUnit.sv
  - sweepUnit.sv
  - gameReferee.sv
  - gameTop.sv
  - target: test
    files:
      - tbClock.sv
      - gameTop_sva.sv
      - gameTop_tb.sv

// ==== gameTop_tb.sv ====
`timescale 1ns/1ps

module gameTop_tb;
    import gamePkg::*;

    localparam logic [1:0] modeHold    = 2'd0;
    localparam logic [1:0] modeSteer   = 2'd1;
    localparam logic [1:0] modeRestart = 2'd2;
    localparam int         rowCount    = 16;

    typedef struct packed {
        logic [1:0]  mode;
        buttons_t    pattern;
        logic        jitter;
        logic        restartEnable;
        speed_t      speed;
        logic [15:0] ticks;
    } stepRow_t;

    // mode, buttons {up down left right centre}, jitter, restartEnable, speed, ticks
    stepRow_t stepTable [rowCount] = '{
        '{modeHold,    5'b00000, 1'b0, 1'b0, 2'd0, 16'd4},
        '{modeHold,    5'b00010, 1'b0, 1'b0, 2'd0, 16'd5},
        '{modeHold,    5'b01100, 1'b0, 1'b0, 2'd0, 16'd5},
        '{modeHold,    5'b11000, 1'b0, 1'b0, 2'd0, 16'd3},
        '{modeHold,    5'b00110, 1'b0, 1'b0, 2'd3, 16'd3},
        '{modeRestart, 5'b00000, 1'b0, 1'b0, 2'd0, 16'd3},
        '{modeRestart, 5'b00000, 1'b0, 1'b1, 2'd0, 16'd2},
        '{modeSteer,   5'b00000, 1'b0, 1'b0, 2'd0, 16'd160},
        '{modeSteer,   5'b00000, 1'b0, 1'b0, 2'd3, 16'd240},
        '{modeHold,    5'b00000, 1'b1, 1'b0, 2'd3, 16'd60},
        '{modeSteer,   5'b00000, 1'b0, 1'b0, 2'd1, 16'd300},
        '{modeHold,    5'b00000, 1'b0, 1'b0, 2'd3, 16'd300},
        '{modeRestart, 5'b00000, 1'b0, 1'b1, 2'd1, 16'd2},
        '{modeHold,    5'b10000, 1'b0, 1'b0, 2'd0, 16'd80},
        '{modeHold,    5'b00000, 1'b1, 1'b1, 2'd2, 16'd40},
        '{modeSteer,   5'b00000, 1'b0, 1'b0, 2'd2, 16'd400}
    };

    logic        slowclk;
    logic        arstN;
    buttons_t    buttons;
    logic        restartEnable;
    speed_t      speed;
    gameView_t   view;
    point_t      mPlayer;
    point_t      mFood;
    point_t      mSeek1;
    point_t      mSeek2;
    point_t      mSweep1;
    point_t      mSweep2;
    size_t       mSize;
    score_t      mScore;
    score_t      mHiscore;
    coordX_t     mCountX;
    coordY_t     mCountY;
    logic [31:0] lfsrState = 32'ha6f5;
    int          errorCount = 0;
    int          checkCount = 0;

    tbClock uClock (.slowclk, .arstN);

    gameTop DUT (.slowclk, .arstN, .buttons, .restartEnable, .speed, .view);

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic closeTo(point_t a, point_t b, int reachX, int reachY);
        int dx;
        int dy;
        dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
        dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
        return (dx < reachX) && (dy < reachY);
    endfunction

    function automatic logic wallTouch(point_t p, int half);
        return (p.x < half + 10) || (p.x > 1429 - half) ||
               (p.y < half + 10) || (p.y > 889 - half);
    endfunction

    function automatic int towards(int from, int to, int step);
        return (to < from) ? from - step : ((to > from) ? from + step : from);
    endfunction

    task automatic startModel(input logic full);
        mPlayer = playerStart;
        mFood   = foodStart;
        mSeek1  = seeker1Start;
        mSeek2  = seeker2Start;
        mSweep1 = sweep1Start;
        mSweep2 = sweep2Start;
        mSize   = startSize;
        mScore  = '0;
        if (full)
        begin
            mHiscore = '0;
            mCountX  = '0;
            mCountY  = '0;
        end
    endtask

    // One game tick of the reference rules, all from the state before the edge
    task automatic advanceModel(input buttons_t b, input logic en, input speed_t sp);
        int     half;
        logic   hazOn;
        logic   dead;
        logic   eatNow;
        logic   knock1;
        logic   knock2;
        point_t spawn;
        half   = mSize / 2;
        hazOn  = mScore > 3;
        dead   = (b.centre && en) || wallTouch(mPlayer, half) ||
                 closeTo(mPlayer, mSeek1, 10 + half, 10 + half) ||
                 closeTo(mPlayer, mSeek2, 10 + half, 10 + half) ||
                 (hazOn && (closeTo(mPlayer, mSweep1, 16 + half, 50 + half) ||
                            closeTo(mPlayer, mSweep2, 16 + half, 50 + half)));
        eatNow = !dead && closeTo(mPlayer, mFood, 8 + half, 8 + half);
        knock1 = hazOn && (closeTo(mSeek1, mSweep1, 26, 60) || closeTo(mSeek1, mSweep2, 26, 60));
        knock2 = hazOn && (closeTo(mSeek2, mSweep1, 26, 60) || closeTo(mSeek2, mSweep2, 26, 60));
        spawn.x = mCountX + 70;
        spawn.y = mCountY + 70;
        mCountX = (mCountX > 1330) ? '0 : mCountX + 17;
        mCountY = (mCountY > 800) ? '0 : mCountY + 29;
        if (dead)
        begin
            startModel(1'b0);
        end
        else
        begin
            if (knock1)
            begin
                mSeek1 = seeker1Start;
            end
            else if (mScore > 0)
            begin
                mSeek1.x = towards(mSeek1.x, mPlayer.x, 1 + sp);
                mSeek1.y = towards(mSeek1.y, mPlayer.y, 1 + sp);
            end
            if (knock2)
            begin
                mSeek2 = seeker2Start;
            end
            else if (mScore > 5)
            begin
                mSeek2.x = towards(mSeek2.x, mPlayer.x, 2 + sp);
                mSeek2.y = towards(mSeek2.y, mPlayer.y, 2 + sp);
            end
            if (hazOn)
            begin
                mSweep1.y = (mSweep1.y >= 890) ? sweep1Start.y : mSweep1.y + 8 + 2 * sp;
                mSweep2.y = (mSweep2.y <= 10) ? sweep2Start.y : mSweep2.y - 8 - 2 * sp;
            end
            if (eatNow)
            begin
                if (mScore == mHiscore)
                begin
                    mHiscore = mScore + 8'd1;
                end
                mScore = mScore + 8'd1;
                mFood  = spawn;
                mSize  = mSize + 8'd3;
            end
            mPlayer.x = mPlayer.x + (b.right ? 6 : 0) - (b.left ? 6 : 0);
            mPlayer.y = mPlayer.y + (b.down ? 6 : 0) - (b.up ? 6 : 0);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        if (got !== exp)
        begin
            errorCount++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareView();
        checkValue("player", view.player, mPlayer);
        checkValue("size", view.size, mSize);
        checkValue("food", view.food, mFood);
        checkValue("seeker1", view.seeker1, mSeek1);
        checkValue("seeker2", view.seeker2, mSeek2);
        checkValue("sweep1", view.sweep1, mSweep1);
        checkValue("sweep2", view.sweep2, mSweep2);
        checkValue("score", view.score, mScore);
        checkValue("hiscore", view.hiscore, mHiscore);
    endtask

    initial
    begin : watchdog
        int total;
        total = 0;
        foreach (stepTable[i])
        begin
            total += stepTable[i].ticks;
        end
        #((total + 53) * 10);
        $display("Timeout: table not finished after %0d ns", (total + 53) * 10);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin : mainFlow
        buttons_t   pick;
        logic [3:0] moves;
        int         rowErrors;
        int         svaFails;
        buttons       = '0;
        restartEnable = 1'b0;
        speed         = '0;
        startModel(1'b1);
        @(posedge arstN);
        compareView();
        $display("test reset: %0d errors", errorCount);
        for (int row = 0; row < rowCount; row++)
        begin
            rowErrors = errorCount;
            for (int t = 0; t < stepTable[row].ticks; t++)
            begin
                pick = stepTable[row].pattern;
                if (stepTable[row].mode == modeSteer)
                begin
                    pick.right = mFood.x > mPlayer.x;
                    pick.left  = mFood.x < mPlayer.x;
                    pick.down  = mFood.y > mPlayer.y;
                    pick.up    = mFood.y < mPlayer.y;
                end
                else if (stepTable[row].mode == modeRestart)
                begin
                    pick.centre = 1'b1;
                end
                else if (stepTable[row].jitter)
                begin
                    for (int i = 0; i < 4; i++)
                    begin
                        lfsrState = lfsrNext(lfsrState);
                        moves[i]  = lfsrState[0];
                    end
                    {pick.up, pick.down, pick.left, pick.right} = moves;
                end
                buttons       = pick;
                restartEnable = stepTable[row].restartEnable;
                speed         = stepTable[row].speed;
                @(posedge slowclk);
                advanceModel(buttons, restartEnable, speed);
                #1;
                compareView();
            end
            $display("test %0d mode %0d speed %0d ticks %0d: %0d errors", row,
                     stepTable[row].mode, stepTable[row].speed, stepTable[row].ticks,
                     errorCount - rowErrors);
        end
        svaFails = DUT.uSva.failCount;
        $display("tests %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 rowCount + 1, checkCount, errorCount, svaFails);
        if (errorCount == 0 && svaFails == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== gameTop_sva.sv ====
`timescale 1ns/1ps

module gameTop_sva (
    input logic            slowclk,
    input logic            arstN,
    input logic            respawn,
    input logic            eat,
    input logic            hazardsOn,
    input gamePkg::score_t score,
    input gamePkg::score_t hiscore,
    input gamePkg::point_t sweep1,
    input gamePkg::point_t sweep2
);

    int failCount = 0;

    // A pickup tick is never overridden by a respawn
    eatRaisesScore: assert property (@(posedge slowclk) disable iff (!arstN)
        eat |=> (score == $past(score) + 8'd1))
    else
    begin
        failCount = failCount + 1;
        $error("score did not rise after eat");
    end

    hiscoreNotBelowScore: assert property (@(posedge slowclk) disable iff (!arstN)
        hiscore >= score)
    else
    begin
        failCount = failCount + 1;
        $error("hiscore fell below score");
    end

    scoreClearedByRespawn: assert property (@(posedge slowclk) disable iff (!arstN)
        respawn |=> (score == '0))
    else
    begin
        failCount = failCount + 1;
        $error("score not cleared after respawn");
    end

    // Sweepers park at their start rows until the hazard score is passed
    sweepersIdle: assert property (@(posedge slowclk) disable iff (!arstN)
        !hazardsOn |=> ($stable(sweep1) && $stable(sweep2)))
    else
    begin
        failCount = failCount + 1;
        $error("sweeper moved while hazards were off");
    end

endmodule

bind gameTop gameTop_sva uSva (
    .slowclk, .arstN, .respawn, .eat, .hazardsOn, .score, .hiscore,
    .sweep1(sweep1Pos), .sweep2(sweep2Pos)
);

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic slowclk,
    output logic arstN
);

    // Reset held for three rising edges
    initial
    begin
        slowclk = 1'b0;
        arstN   = 1'b0;
        repeat (3) @(posedge slowclk);
        #1 arstN = 1'b1;
    end

    always #5 slowclk = ~slowclk;

endmodule

// ==== gameTop.sv ====
`timescale 1ns/1ps

module gameTop (
    input  logic               slowclk,
    input  logic               arstN,
    input  gamePkg::buttons_t  buttons,
    input  logic               restartEnable,
    input  gamePkg::speed_t    speed,
    output gamePkg::gameView_t view
);
    import gamePkg::*;

    point_t playerPos;
    size_t  playerSize;
    point_t foodPos;
    point_t spawnPos;
    point_t seeker1Pos;
    point_t seeker2Pos;
    point_t sweep1Pos;
    point_t sweep2Pos;
    score_t score;
    score_t hiscore;
    logic   respawn;
    logic   eat;
    logic   hazardsOn;
    logic   knock1;
    logic   knock2;

    spawnPicker uSpawn (.slowclk, .arstN, .spawn(spawnPos));

    playerUnit uPlayer (
        .slowclk, .arstN, .respawn, .eat, .buttons,
        .pos(playerPos), .size(playerSize)
    );

    chaserUnit #(.startPos(seeker1Start), .stepBase(seeker1Base), .wakeAbove(seeker1Wake))
    uSeeker1 (
        .slowclk, .arstN, .respawn, .knock(knock1), .target(playerPos),
        .score, .speed, .pos(seeker1Pos)
    );

    chaserUnit #(.startPos(seeker2Start), .stepBase(seeker2Base), .wakeAbove(seeker2Wake))
    uSeeker2 (
        .slowclk, .arstN, .respawn, .knock(knock2), .target(playerPos),
        .score, .speed, .pos(seeker2Pos)
    );

    // Sweep1 runs downward, sweep2 upward
    sweepUnit #(.startPos(sweep1Start), .moveDown(1'b1))
    uSweep1 (.slowclk, .arstN, .respawn, .hazardsOn, .speed, .pos(sweep1Pos));

    sweepUnit #(.startPos(sweep2Start), .moveDown(1'b0))
    uSweep2 (.slowclk, .arstN, .respawn, .hazardsOn, .speed, .pos(sweep2Pos));

    gameReferee uReferee (
        .slowclk, .arstN, .buttons, .restartEnable,
        .player(playerPos), .seeker1(seeker1Pos), .seeker2(seeker2Pos),
        .sweep1(sweep1Pos), .sweep2(sweep2Pos), .spawn(spawnPos), .size(playerSize),
        .respawn, .eat, .hazardsOn, .knock1, .knock2,
        .food(foodPos), .score, .hiscore
    );

    assign view = '{player: playerPos, size: playerSize, food: foodPos,
                    seeker1: seeker1Pos, seeker2: seeker2Pos,
                    sweep1: sweep1Pos, sweep2: sweep2Pos,
                    score: score, hiscore: hiscore};

endmodule

// ==== gameReferee.sv ====
`timescale 1ns/1ps

module gameReferee (
    input  logic              slowclk,
    input  logic              arstN,
    input  gamePkg::buttons_t buttons,
    input  logic              restartEnable,
    input  gamePkg::point_t   player,
    input  gamePkg::point_t   seeker1,
    input  gamePkg::point_t   seeker2,
    input  gamePkg::point_t   sweep1,
    input  gamePkg::point_t   sweep2,
    input  gamePkg::point_t   spawn,
    input  gamePkg::size_t    size,
    output logic              respawn,
    output logic              eat,
    output logic              hazardsOn,
    output logic              knock1,
    output logic              knock2,
    output gamePkg::point_t   food,
    output gamePkg::score_t   score,
    output gamePkg::score_t   hiscore
);
    import gamePkg::*;

    int unsigned halfSize;
    logic        restart;
    logic        wallTouch;
    logic        seekerTouch;
    logic        sweepTouch;

    assign halfSize  = size >> 1;
    assign hazardsOn = score > hazardScore;

    ////////////////////////////////////////////////////////////////////////////
    // Death, restart and pickup
    ////////////////////////////////////////////////////////////////////////////
    assign restart   = buttons.centre && restartEnable;
    assign wallTouch = hitsWall(player, size);

    // Seekers are deadly at any score
    assign seekerTouch =
        near(player, seeker1, seekerHalf + halfSize, seekerHalf + halfSize) ||
        near(player, seeker2, seekerHalf + halfSize, seekerHalf + halfSize);

    assign sweepTouch = hazardsOn &&
        (near(player, sweep1, sweepHalfX + halfSize, sweepHalfY + halfSize) ||
         near(player, sweep2, sweepHalfX + halfSize, sweepHalfY + halfSize));

    assign respawn = restart || wallTouch || seekerTouch || sweepTouch;
    assign eat     = !respawn &&
                     near(player, food, foodHalf + halfSize, foodHalf + halfSize);

    // Sweeper against seeker, both extents added
    assign knock1 = hazardsOn &&
        (near(seeker1, sweep1, sweepHalfX + seekerHalf, sweepHalfY + seekerHalf) ||
         near(seeker1, sweep2, sweepHalfX + seekerHalf, sweepHalfY + seekerHalf));

    assign knock2 = hazardsOn &&
        (near(seeker2, sweep1, sweepHalfX + seekerHalf, sweepHalfY + seekerHalf) ||
         near(seeker2, sweep2, sweepHalfX + seekerHalf, sweepHalfY + seekerHalf));

    ////////////////////////////////////////////////////////////////////////////
    // Food, score and high score
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge slowclk or negedge arstN)
    begin
        if (!arstN)
        begin
            food    <= foodStart;
            score   <= '0;
            hiscore <= '0;
        end
        else if (respawn)
        begin
            // High score survives a death
            food  <= foodStart;
            score <= '0;
        end
        else if (eat)
        begin
            score <= score + 8'd1;
            food  <= spawn;
            if (score == hiscore)
            begin
                hiscore <= score + 8'd1;
            end
        end
    end

endmodule

// ==== sweepUnit.sv ====
`timescale 1ns/1ps

module sweepUnit #(
    parameter gamePkg::point_t startPos = gamePkg::sweep1Start,
    parameter bit              moveDown = 1'b1
) (
    input  logic            slowclk,
    input  logic            arstN,
    input  logic            respawn,
    input  logic            hazardsOn,
    input  gamePkg::speed_t speed,
    output gamePkg::point_t pos
);
    import gamePkg::*;

    logic [4:0] step;
    logic       atEdge;

    // Base step plus two per speed level
    assign step   = 5'(sweepBase) + 5'({speed, 1'b0});
    assign atEdge = moveDown ? (pos.y >= sweepBottom) : (pos.y <= sweepTop);

    // Only the row moves, the column stays fixed
    always_ff @(posedge slowclk or negedge arstN)
    begin
        if (!arstN)
        begin
            pos <= startPos;
        end
        else if (respawn)
        begin
            pos <= startPos;
        end
        else if (hazardsOn)
        begin
            if (atEdge)
            begin
                pos.y <= startPos.y;
            end
            else
            begin
                pos.y <= moveDown ? pos.y + coordY_t'(step) : pos.y - coordY_t'(step);
            end
        end
    end

endmodule

// ==== chaserUnit.sv ====
`timescale 1ns/1ps

module chaserUnit #(
    parameter gamePkg::point_t startPos  = gamePkg::seeker1Start,
    parameter int unsigned     stepBase  = gamePkg::seeker1Base,
    parameter gamePkg::score_t wakeAbove = gamePkg::seeker1Wake
) (
    input  logic            slowclk,
    input  logic            arstN,
    input  logic            respawn,
    input  logic            knock,
    input  gamePkg::point_t target,
    input  gamePkg::score_t score,
    input  gamePkg::speed_t speed,
    output gamePkg::point_t pos
);
    import gamePkg::*;

    logic [3:0] step;
    logic       awake;

    // Faster with every speed level
    assign step  = 4'(stepBase) + 4'(speed);
    assign awake = score > wakeAbove;

    always_ff @(posedge slowclk or negedge arstN)
    begin
        if (!arstN)
        begin
            pos <= startPos;
        end
        else if (respawn || knock)
        begin
            pos <= startPos;
        end
        else if (awake)
        begin
            if (target.x < pos.x)
            begin
                pos.x <= pos.x - coordX_t'(step);
            end
            else if (target.x > pos.x)
            begin
                pos.x <= pos.x + coordX_t'(step);
            end
            if (target.y < pos.y)
            begin
                pos.y <= pos.y - coordY_t'(step);
            end
            else if (target.y > pos.y)
            begin
                pos.y <= pos.y + coordY_t'(step);
            end
        end
    end

endmodule

// ==== playerUnit.sv ====
`timescale 1ns/1ps

module playerUnit (
    input  logic              slowclk,
    input  logic              arstN,
    input  logic              respawn,
    input  logic              eat,
    input  gamePkg::buttons_t buttons,
    output gamePkg::point_t   pos,
    output gamePkg::size_t    size
);
    import gamePkg::*;

    coordX_t stepRight;
    coordX_t stepLeft;
    coordY_t stepDown;
    coordY_t stepUp;

    // Opposite buttons cancel out
    assign stepRight = buttons.right ? coordX_t'(moveStep) : '0;
    assign stepLeft  = buttons.left  ? coordX_t'(moveStep) : '0;
    assign stepDown  = buttons.down  ? coordY_t'(moveStep) : '0;
    assign stepUp    = buttons.up    ? coordY_t'(moveStep) : '0;

    always_ff @(posedge slowclk or negedge arstN)
    begin
        if (!arstN)
        begin
            pos  <= playerStart;
            size <= startSize;
        end
        else if (respawn)
        begin
            pos  <= playerStart;
            size <= startSize;
        end
        else
        begin
            pos.x <= pos.x + stepRight - stepLeft;
            pos.y <= pos.y + stepDown - stepUp;
            if (eat)
            begin
                size <= size + size_t'(growStep);
            end
        end
    end

endmodule

// ==== spawnPicker.sv ====
`timescale 1ns/1ps

module spawnPicker (
    input  logic            slowclk,
    input  logic            arstN,
    output gamePkg::point_t spawn
);
    import gamePkg::*;

    coordX_t countX;
    coordY_t countY;

    // Both counters run on every tick, respawn or not
    always_ff @(posedge slowclk or negedge arstN)
    begin
        if (!arstN)
        begin
            countX <= '0;
            countY <= '0;
        end
        else
        begin
            countX <= (countX > spawnLimitX) ? '0 : countX + spawnStepX;
            countY <= (countY > spawnLimitY) ? '0 : countY + spawnStepY;
        end
    end

    assign spawn = '{x: countX + coordX_t'(spawnOffset),
                     y: countY + coordY_t'(spawnOffset)};

endmodule

// ==== gamePkg.sv ====
package gamePkg;

    typedef logic [10:0] coordX_t;
    typedef logic [9:0]  coordY_t;
    typedef logic [7:0]  size_t;
    typedef logic [7:0]  score_t;
    typedef logic [1:0]  speed_t;

    typedef struct packed {
        coordX_t x;
        coordY_t y;
    } point_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic centre;
    } buttons_t;

    typedef struct packed {
        point_t player;
        size_t  size;
        point_t food;
        point_t seeker1;
        point_t seeker2;
        point_t sweep1;
        point_t sweep2;
        score_t score;
        score_t hiscore;
    } gameView_t;

    ////////////////////////////////////////////////////////////////////////////
    // Start positions and player geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam point_t playerStart  = '{x: 11'd720,  y: 10'd450};
    localparam point_t foodStart    = '{x: 11'd700,  y: 10'd800};
    localparam point_t seeker1Start = '{x: 11'd150,  y: 10'd0};
    localparam point_t seeker2Start = '{x: 11'd1250, y: 10'd0};
    localparam point_t sweep1Start  = '{x: 11'd350,  y: 10'd60};
    localparam point_t sweep2Start  = '{x: 11'd1000, y: 10'd839};
    localparam size_t  startSize    = 8'd32;
    localparam int unsigned growStep = 3;
    localparam int unsigned moveStep = 6;

    // Half extents of the objects
    localparam int unsigned foodHalf   = 8;
    localparam int unsigned seekerHalf = 10;
    localparam int unsigned sweepHalfX = 16;
    localparam int unsigned sweepHalfY = 50;

    localparam int unsigned wallMargin  = 10;
    localparam int unsigned arenaRight  = 1429;
    localparam int unsigned arenaBottom = 889;
    localparam coordY_t     sweepBottom = 10'd890;
    localparam coordY_t     sweepTop    = 10'd10;
    localparam int unsigned spawnOffset = 70;

    localparam coordX_t spawnStepX  = 11'd17;
    localparam coordX_t spawnLimitX = 11'd1330;
    localparam coordY_t spawnStepY  = 10'd29;
    localparam coordY_t spawnLimitY = 10'd800;

    ////////////////////////////////////////////////////////////////////////////
    // Rules
    ////////////////////////////////////////////////////////////////////////////
    localparam score_t      hazardScore = 8'd3;
    localparam int unsigned sweepBase   = 8;
    localparam int unsigned seeker1Base = 1;
    localparam int unsigned seeker2Base = 2;
    localparam score_t      seeker1Wake = 8'd0;
    localparam score_t      seeker2Wake = 8'd5;

    // True when both axis distances are strictly inside the reach
    function automatic logic near(point_t a, point_t b, int unsigned reachX,
                                  int unsigned reachY);
        coordX_t dx;
        coordY_t dy;
        dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
        dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
        return (dx < reachX) && (dy < reachY);
    endfunction

    function automatic logic hitsWall(point_t p, size_t size);
        int unsigned half;
        half = size >> 1;
        return (p.x < half + wallMargin) || (p.x > arenaRight - half) ||
               (p.y < half + wallMargin) || (p.y > arenaBottom - half);
    endfunction

endpackage
